/* core_pkg.sv */
package core_pkg;

  localparam int word_width      = 32;
  localparam int prog_addr_width = 8;
  localparam int main_addr_width = 8;
  localparam int dstack_depth    = 16;
  localparam int cstack_depth    = 4;
  localparam int op_width        = 8;
  localparam int prog_word_width = op_width + word_width;

  // The top two data stack entries live in registers, the rest in a small array
  localparam int dstack_cnt_width = $clog2(dstack_depth + 1);
  localparam int dstack_ram_depth = dstack_depth - 2;
  localparam int dstack_idx_width = $clog2(dstack_ram_depth);
  localparam int cstack_cnt_width = $clog2(cstack_depth + 1);

  typedef logic [word_width-1:0]      word_t;
  typedef logic [prog_addr_width-1:0] prog_addr_t;
  typedef logic [main_addr_width-1:0] main_addr_t;

  // Codes not listed here execute as a nop
  typedef enum logic [op_width-1:0] {
    op_nop    = 8'h00,
    op_pushi  = 8'h01,
    op_dup    = 8'h02,
    op_drop   = 8'h03,
    op_swap   = 8'h04,
    op_add    = 8'h10,
    op_addc   = 8'h11,
    op_sub    = 8'h12,
    op_and    = 8'h13,
    op_or     = 8'h14,
    op_xor    = 8'h15,
    op_jumpi  = 8'h20,
    op_bzi    = 8'h21,
    op_calli  = 8'h22,
    op_return = 8'h23,
    op_store  = 8'h30,
    op_halt   = 8'hff
  } opcode_e;

  typedef enum logic [2:0] {
    stk_keep,
    stk_push,
    stk_pop,
    stk_pop2,
    stk_swap
  } stack_move_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_addc,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

  typedef enum logic [1:0] {
    src_alu,
    src_imm,
    src_top,
    src_second
  } top_src_e;

  typedef struct packed {
    stack_move_e move;
    logic [1:0]  needs;
    top_src_e    top_src;
    alu_op_e     alu_op;
    logic        set_carry;
    logic        jump;
    logic        branch_zero;
    logic        call;
    logic        ret;
    logic        store;
    logic        halt;
  } ctrl_t;

  typedef struct packed {
    logic       we;
    main_addr_t addr;
    word_t      data;
  } mem_wr_t;

endpackage

/* data_stack.sv */
`timescale 1ns/1ns

module data_stack (
  input  logic            clk,
  input  logic            arst_n,
  input  core_pkg::ctrl_t ctrl,
  input  core_pkg::word_t imm,
  input  core_pkg::word_t result,
  output core_pkg::word_t top,
  output core_pkg::word_t second,
  output logic            stack_err
);
  import core_pkg::*;

  word_t                       top_q;
  word_t                       second_q;
  word_t                       spill [dstack_ram_depth];
  logic [dstack_cnt_width-1:0] depth;
  logic [dstack_idx_width-1:0] push_idx;
  logic [dstack_idx_width-1:0] third_idx;
  logic [dstack_idx_width-1:0] fourth_idx;
  word_t                       third;
  word_t                       fourth;
  word_t                       new_top;
  logic                        underflow;
  logic                        overflow;

  // Entry n of the stack (counting the top as 1) is held in spill[depth-n]
  assign push_idx   = dstack_idx_width'(depth - 2);
  assign third_idx  = dstack_idx_width'(depth - 3);
  assign fourth_idx = dstack_idx_width'(depth - 4);

  assign third  = (depth >= 3) ? spill[third_idx] : '0;
  assign fourth = (depth >= 4) ? spill[fourth_idx] : '0;

  assign underflow = depth < dstack_cnt_width'(ctrl.needs);
  assign overflow  = (ctrl.move == stk_push) && (depth == dstack_cnt_width'(dstack_depth));
  assign stack_err = underflow || overflow;

  always_comb begin
    case (ctrl.top_src)
      src_alu:    new_top = result;
      src_imm:    new_top = imm;
      src_second: new_top = second_q;
      default:    new_top = top_q;
    endcase
  end

  // A failed operand check freezes the whole stack for that instruction
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      depth    <= '0;
      top_q    <= '0;
      second_q <= '0;
    end else if (!stack_err) begin
      case (ctrl.move)
        stk_keep: top_q <= new_top;
        stk_push: begin
          top_q    <= new_top;
          second_q <= top_q;
          depth    <= depth + 1'b1;
        end
        stk_pop: begin
          top_q    <= new_top;
          second_q <= third;
          depth    <= depth - 1'b1;
        end
        stk_pop2: begin
          top_q    <= third;
          second_q <= fourth;
          depth    <= depth - 2'd2;
        end
        stk_swap: begin
          top_q    <= second_q;
          second_q <= top_q;
        end
        default: ;
      endcase
    end
  end

  // The old second entry sinks into the array on a push
  always_ff @(posedge clk) begin
    if (!stack_err && ctrl.move == stk_push && depth >= 2) begin
      spill[push_idx] <= second_q;
    end
  end

  assign top    = top_q;
  assign second = second_q;

  depth_bound: assert property (@(posedge clk) disable iff (!arst_n)
    depth <= dstack_cnt_width'(dstack_depth));

endmodule

/* instr_decode.sv */
`timescale 1ns/1ns

module instr_decode (
  input  logic [core_pkg::prog_word_width-1:0] prog_data,
  output core_pkg::ctrl_t                      ctrl,
  output core_pkg::word_t                      imm
);
  import core_pkg::*;

  opcode_e op;

  // Opcode sits in the low byte, the immediate fills the rest of the word
  assign op  = opcode_e'(prog_data[op_width-1:0]);
  assign imm = prog_data[prog_word_width-1:op_width];

  always_comb begin
    ctrl         = '0;
    ctrl.move    = stk_keep;
    ctrl.top_src = src_top;
    ctrl.alu_op  = alu_add;
    case (op)
      op_pushi: begin
        ctrl.move    = stk_push;
        ctrl.top_src = src_imm;
      end
      op_add, op_addc, op_sub, op_and, op_or, op_xor: begin
        ctrl.move    = stk_pop;
        ctrl.needs   = 2'd2;
        ctrl.top_src = src_alu;
        case (op)
          op_add:  ctrl.alu_op = alu_add;
          op_addc: ctrl.alu_op = alu_addc;
          op_sub:  ctrl.alu_op = alu_sub;
          op_and:  ctrl.alu_op = alu_and;
          op_or:   ctrl.alu_op = alu_or;
          default: ctrl.alu_op = alu_xor;
        endcase
        ctrl.set_carry = (op == op_add) || (op == op_addc) || (op == op_sub);
      end
      op_dup: begin
        ctrl.move  = stk_push;
        ctrl.needs = 2'd1;
      end
      op_drop: begin
        ctrl.move    = stk_pop;
        ctrl.needs   = 2'd1;
        ctrl.top_src = src_second;
      end
      op_swap: begin
        ctrl.move  = stk_swap;
        ctrl.needs = 2'd2;
      end
      op_jumpi: ctrl.jump = 1'b1;
      // The condition is consumed whether or not the branch is taken
      op_bzi: begin
        ctrl.move        = stk_pop;
        ctrl.needs       = 2'd1;
        ctrl.top_src     = src_second;
        ctrl.branch_zero = 1'b1;
      end
      op_calli:  ctrl.call = 1'b1;
      op_return: ctrl.ret = 1'b1;
      op_store: begin
        ctrl.move  = stk_pop2;
        ctrl.needs = 2'd2;
        ctrl.store = 1'b1;
      end
      op_halt: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

  // The sequencer relies on the flow bits being mutually exclusive
  flow_onehot: assert #0 ($onehot0({ctrl.jump, ctrl.call, ctrl.ret, ctrl.branch_zero}));

endmodule

/* list.f */
+incdir+.
core_pkg.sv
instr_decode.sv
data_stack.sv
stack_alu.sv
pc_sequencer.sv
store_port.sv
stack_core.sv
tb_stack_core.sv

/* pc_sequencer.sv */
`timescale 1ns/1ns

module pc_sequencer (
  input  logic                 clk,
  input  logic                 arst_n,
  input  core_pkg::ctrl_t      ctrl,
  input  core_pkg::word_t      imm,
  input  core_pkg::word_t      top,
  output core_pkg::prog_addr_t prog_addr
);
  import core_pkg::*;

  prog_addr_t                  pc;
  prog_addr_t                  pc_inc;
  prog_addr_t                  pc_next;
  prog_addr_t                  cstack [cstack_depth];
  logic [cstack_cnt_width-1:0] ccount;

  assign pc_inc = pc + 1'b1;

  always_comb begin
    if (ctrl.halt) begin
      pc_next = pc;
    end else if (ctrl.ret) begin
      // Returning with nothing on the call stack restarts the program
      pc_next = (ccount == '0) ? '0 : cstack[0];
    end else if (ctrl.jump || ctrl.call) begin
      pc_next = imm[prog_addr_width-1:0];
    end else if (ctrl.branch_zero && top == '0) begin
      pc_next = imm[prog_addr_width-1:0];
    end else begin
      pc_next = pc_inc;
    end
  end

  // Word 0 must be fetched while the core is held in reset
  assign prog_addr = arst_n ? pc_next : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= '0;
      ccount <= '0;
    end else begin
      pc <= pc_next;
      if (ctrl.call) begin
        if (ccount != cstack_cnt_width'(cstack_depth)) begin
          ccount <= ccount + 1'b1;
        end
      end else if (ctrl.ret && ccount != '0) begin
        ccount <= ccount - 1'b1;
      end
    end
  end

  // Entry 0 is the newest, a push past the last entry loses the oldest
  always_ff @(posedge clk) begin
    if (ctrl.call) begin
      cstack[0] <= pc_inc;
      for (int i = 1; i < cstack_depth; i++) begin
        cstack[i] <= cstack[i-1];
      end
    end else if (ctrl.ret) begin
      for (int i = 0; i < cstack_depth - 1; i++) begin
        cstack[i] <= cstack[i+1];
      end
    end
  end

  call_ret_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(ctrl.call && ctrl.ret));

endmodule

/* stack_alu.sv */
`timescale 1ns/1ns

module stack_alu (
  input  logic            clk,
  input  logic            arst_n,
  input  core_pkg::ctrl_t ctrl,
  input  core_pkg::word_t top,
  input  core_pkg::word_t second,
  output core_pkg::word_t result
);
  import core_pkg::*;

  logic                carry_q;
  logic [word_width:0] sum;

  // Bit word_width of sum is the carry out, or the borrow for a subtract
  always_comb begin
    case (ctrl.alu_op)
      alu_add:  sum = {1'b0, second} + {1'b0, top};
      alu_addc: sum = {1'b0, second} + {1'b0, top} + (word_width + 1)'(carry_q);
      alu_sub:  sum = {1'b0, second} - {1'b0, top};
      alu_and:  sum = {1'b0, second & top};
      alu_or:   sum = {1'b0, second | top};
      alu_xor:  sum = {1'b0, second ^ top};
      default:  sum = '0;
    endcase
  end

  assign result = sum[word_width-1:0];

  // Subtract keeps the inverted borrow so that a chained addc works as in most ISAs
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      carry_q <= 1'b0;
    end else if (ctrl.set_carry) begin
      if (ctrl.alu_op == alu_sub) begin
        carry_q <= ~sum[word_width];
      end else begin
        carry_q <= sum[word_width];
      end
    end
  end

endmodule

/* stack_core.sv */
`timescale 1ns/1ns

module stack_core (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [core_pkg::prog_word_width-1:0] prog_data,
  output core_pkg::prog_addr_t                 prog_addr,
  output core_pkg::mem_wr_t                    mem_wr,
  output logic                                 stack_error
);
  import core_pkg::*;

  ctrl_t ctrl;
  word_t imm;
  word_t top;
  word_t second;
  word_t result;
  logic  stack_err;

  instr_decode i_decode (
    .prog_data (prog_data),
    .ctrl      (ctrl),
    .imm       (imm)
  );

  data_stack i_dstack (
    .clk       (clk),
    .arst_n    (arst_n),
    .ctrl      (ctrl),
    .imm       (imm),
    .result    (result),
    .top       (top),
    .second    (second),
    .stack_err (stack_err)
  );

  stack_alu i_alu (
    .clk    (clk),
    .arst_n (arst_n),
    .ctrl   (ctrl),
    .top    (top),
    .second (second),
    .result (result)
  );

  pc_sequencer i_seq (
    .clk       (clk),
    .arst_n    (arst_n),
    .ctrl      (ctrl),
    .imm       (imm),
    .top       (top),
    .prog_addr (prog_addr)
  );

  store_port i_store (
    .clk         (clk),
    .arst_n      (arst_n),
    .ctrl        (ctrl),
    .top         (top),
    .second      (second),
    .stack_err   (stack_err),
    .mem_wr      (mem_wr),
    .stack_error (stack_error)
  );

endmodule

/* store_port.sv */
`timescale 1ns/1ns

module store_port (
  input  logic              clk,
  input  logic              arst_n,
  input  core_pkg::ctrl_t   ctrl,
  input  core_pkg::word_t   top,
  input  core_pkg::word_t   second,
  input  logic              stack_err,
  output core_pkg::mem_wr_t mem_wr,
  output logic              stack_error
);
  import core_pkg::*;

  logic       we_q;
  main_addr_t addr_q;
  word_t      data_q;
  logic       err_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      we_q  <= 1'b0;
      err_q <= 1'b0;
    end else begin
      // A store whose operands were missing never reaches memory
      we_q <= ctrl.store && !stack_err;
      if (stack_err) begin
        err_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.store) begin
      addr_q <= top[main_addr_width-1:0];
      data_q <= second;
    end
  end

  assign mem_wr      = '{we: we_q, addr: addr_q, data: data_q};
  assign stack_error = err_q;

endmodule

/* tb_tests.svh */
`ifndef tb_tests_svh
`define tb_tests_svh

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x         = rnd_state;
    x         = x ^ (x << 13);
    x         = x ^ (x >> 17);
    x         = x ^ (x << 5);
    rnd_state = x;
    return x;
  endfunction

  // Each operation takes the older operand as the left side
  task automatic test_arithmetic();
    opcode_e ops [5];
    word_t   a;
    word_t   b;
    word_t   r;
    ops = '{op_add, op_sub, op_and, op_or, op_xor};
    start_test();
    for (int i = 0; i < 10; i++) begin
      a = xorshift32();
      b = xorshift32();
      case (i % 5)
        0:       r = a + b;
        1:       r = a - b;
        2:       r = a & b;
        3:       r = a | b;
        default: r = a ^ b;
      endcase
      emit(op_pushi, a);
      emit(op_pushi, b);
      emit(ops[i % 5], '0);
      emit(op_pushi, word_t'(8'h10 + i));
      emit(op_store, '0);
      expect_write(main_addr_t'(8'h10 + i), r);
    end
    emit(op_halt, '0);
    run_program();
    compare_writes();
    check_eq("stack_error", stack_error, 0);
  endtask

  // The carry comes back as the result of addc on two zeros
  task automatic test_carry();
    opcode_e op;
    word_t   a;
    word_t   b;
    word_t   low;
    logic    carry;
    start_test();
    for (int i = 0; i < 4; i++) begin
      a = (xorshift32() >> 1) | 32'h1;
      // Add with wrap, add without wrap, sub without borrow, sub with borrow
      case (i)
        0:       b = ~a + 1'b1;
        1:       b = xorshift32() >> 1;
        2:       b = a >> 1;
        default: b = a + 1'b1;
      endcase
      if (i < 2) begin
        op    = op_add;
        // An add wraps when the 32-bit sum ends up below one of its operands
        low   = a + b;
        carry = (low < a);
      end else begin
        op    = op_sub;
        carry = (a >= b);
      end
      emit(op_pushi, a);
      emit(op_pushi, b);
      emit(op, '0);
      emit(op_drop, '0);
      emit(op_pushi, '0);
      emit(op_pushi, '0);
      emit(op_addc, '0);
      emit(op_pushi, word_t'(8'h20 + i));
      emit(op_store, '0);
      expect_write(main_addr_t'(8'h20 + i), word_t'(carry));
    end
    emit(op_halt, '0);
    run_program();
    compare_writes();
    check_eq("stack_error", stack_error, 0);
  endtask

  task automatic test_shuffle();
    word_t vals [6];
    for (int i = 0; i < 6; i++) begin
      vals[i] = xorshift32();
    end
    start_test();
    // The store takes the copy made by dup and leaves the original behind
    emit(op_pushi, vals[0]);
    emit(op_dup, '0);
    emit(op_pushi, 32'h30);
    emit(op_store, '0);
    expect_write(8'h30, vals[0]);
    emit(op_pushi, vals[1]);
    emit(op_swap, '0);
    emit(op_pushi, 32'h31);
    emit(op_store, '0);
    expect_write(8'h31, vals[0]);
    // Dropping the newest value brings the one below back to the top
    emit(op_pushi, vals[2]);
    emit(op_drop, '0);
    emit(op_pushi, 32'h32);
    emit(op_store, '0);
    expect_write(8'h32, vals[1]);
    for (int i = 0; i < 6; i++) begin
      emit(op_pushi, vals[i]);
    end
    for (int i = 0; i < 6; i++) begin
      emit(op_pushi, word_t'(8'h33 + i));
      emit(op_store, '0);
      expect_write(main_addr_t'(8'h33 + i), vals[5 - i]);
    end
    emit(op_halt, '0);
    run_program();
    compare_writes();
    check_eq("stack_error", stack_error, 0);
  endtask

  // The jump skips words 1 to 3 and the zero branch skips 6 to 8
  // The nonzero branch falls through into 11 and the program halts at 17
  task automatic test_branch();
    word_t m [4];
    for (int i = 0; i < 4; i++) begin
      m[i] = xorshift32();
    end
    start_test();
    emit(op_jumpi, 32'd4);
    emit_store(m[0], 8'h40, 1'b0);
    emit(op_pushi, '0);
    emit(op_bzi, 32'd9);
    emit_store(m[1], 8'h41, 1'b0);
    emit(op_pushi, xorshift32() | 32'h1);
    emit(op_bzi, 32'd14);
    emit_store(m[2], 8'h42, 1'b1);
    emit_store(m[3], 8'h43, 1'b1);
    emit(op_halt, '0);
    run_program();
    compare_writes();
    check_eq("prog_addr", prog_addr, 17);
    check_eq("stack_error", stack_error, 0);
  endtask

  // Main calls 24, which calls 34; the final return on an empty call stack restarts at 0
  task automatic test_call_return();
    word_t m [6];
    for (int i = 0; i < 6; i++) begin
      m[i] = xorshift32();
    end
    start_test();
    emit_store(m[0], 8'h50, 1'b0);
    // Carry is clear only on the first pass, so the branch to 8 is skipped after the restart
    emit(op_pushi, '0);
    emit(op_pushi, '0);
    emit(op_addc, '0);
    emit(op_bzi, 32'd8);
    emit(op_halt, '0);
    emit_store(m[1], 8'h51, 1'b0);
    emit(op_calli, 32'd24);
    emit_store(m[5], 8'h55, 1'b0);
    emit(op_pushi, 32'hffff_ffff);
    emit(op_pushi, 32'h1);
    emit(op_add, '0);
    emit(op_drop, '0);
    emit(op_return, '0);
    load_ptr = 24;
    emit_store(m[2], 8'h52, 1'b0);
    emit(op_calli, 32'd34);
    emit_store(m[4], 8'h54, 1'b0);
    emit(op_return, '0);
    load_ptr = 34;
    emit_store(m[3], 8'h53, 1'b0);
    emit(op_return, '0);
    for (int i = 0; i < 6; i++) begin
      expect_write(main_addr_t'(8'h50 + i), m[i]);
    end
    expect_write(8'h50, m[0]);
    run_program();
    compare_writes();
    check_eq("prog_addr", prog_addr, 7);
    check_eq("stack_error", stack_error, 0);
  endtask

  task automatic test_error_halt();
    int    n_writes;
    word_t d;
    d = xorshift32();
    start_test();
    emit(op_drop, '0);
    // Only an address is on the stack, so this store must not reach memory
    emit(op_pushi, 32'h60);
    emit(op_store, '0);
    emit(op_drop, '0);
    emit_store(d, 8'h61, 1'b1);
    emit(op_halt, '0);
    emit_store(~d, 8'h62, 1'b0);
    run_program();
    check_eq("stack_error", stack_error, 1);
    check_eq("prog_addr", prog_addr, 7);
    n_writes = got_q.size();
    repeat (8) @(negedge clk);
    check_eq("stack_error", stack_error, 1);
    check_eq("prog_addr", prog_addr, 7);
    check_eq("write count after halt", got_q.size(), n_writes);
    compare_writes();
  endtask

`endif

/* tb_stack_core.sv */
`timescale 1ns/1ns

module tb_stack_core;
  import core_pkg::*;

  localparam int reset_cycles   = 16;
  localparam int timeout_cycles = 6 * 200;

  logic                       clk;
  logic                       arst_n;
  logic [prog_word_width-1:0] prog_data;
  prog_addr_t                 prog_addr;
  mem_wr_t                    mem_wr;
  logic                       stack_error;

  logic [prog_word_width-1:0] prog_mem [256];
  mem_wr_t                    got_q [$];
  mem_wr_t                    exp_q [$];
  int                         load_ptr;
  int                         cycle_count;
  int                         checks;
  int                         errors;
  logic [31:0]                rnd_state;

  stack_core i_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .prog_data   (prog_data),
    .prog_addr   (prog_addr),
    .mem_wr      (mem_wr),
    .stack_error (stack_error)
  );

  always #2 clk = ~clk;

  // Program memory answers one cycle after the address
  always @(posedge clk) begin
    prog_data <= prog_mem[prog_addr];
  end

  // A write strobe is one cycle wide, so sampling once per cycle records it once
  always @(negedge clk) begin
    if (arst_n && mem_wr.we) begin
      got_q.push_back(mem_wr);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      $display("Run timed out after %0d cycles, the core never settled", cycle_count);
      $display("%0d checks, %0d errors", checks, errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic expect_write(input main_addr_t addr, input word_t data);
    exp_q.push_back('{we: 1'b1, addr: addr, data: data});
  endtask

  task automatic emit(input opcode_e op, input word_t imm);
    prog_mem[load_ptr] = {imm, op};
    load_ptr++;
  endtask

  // Pushes data and address, then stores; reached marks a write the program will make
  task automatic emit_store(input word_t data, input main_addr_t addr, input logic reached);
    emit(op_pushi, data);
    emit(op_pushi, word_t'(addr));
    emit(op_store, '0);
    if (reached) begin
      expect_write(addr, data);
    end
  endtask

  // Holds the core in reset, fills unused words with halt and clears the write records
  task automatic start_test();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (reset_cycles - 1) @(posedge clk);
    got_q.delete();
    exp_q.delete();
    load_ptr = 0;
    for (int a = 0; a < 256; a++) begin
      prog_mem[a] = {word_t'(a), op_halt};
    end
  endtask

  // Releases reset and runs until the fetch address has not moved for 4 cycles
  task automatic run_program();
    prog_addr_t last;
    int         stable;
    @(negedge clk);
    check_eq("prog_addr in reset", prog_addr, 0);
    check_eq("mem_wr.we in reset", mem_wr.we, 0);
    check_eq("stack_error in reset", stack_error, 0);
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    last   = prog_addr;
    stable = 0;
    while (stable < 4) begin
      @(negedge clk);
      if (prog_addr == last) begin
        stable++;
      end else begin
        last   = prog_addr;
        stable = 0;
      end
    end
  endtask

  task automatic compare_writes();
    check_eq("write count", got_q.size(), exp_q.size());
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      check_eq($sformatf("mem_wr.addr[%0d]", i), got_q[i].addr, exp_q[i].addr);
      check_eq($sformatf("mem_wr.data[%0d]", i), got_q[i].data, exp_q[i].data);
    end
  endtask

  `include "tb_tests.svh"

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    prog_data   = '0;
    rnd_state   = 32'h859c;
    load_ptr    = 0;
    cycle_count = 0;
    checks      = 0;
    errors      = 0;
    test_arithmetic();
    test_carry();
    test_shuffle();
    test_branch();
    test_call_return();
    test_error_halt();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
